/* bench/frame_loop_tb.sv */
`timescale 1ns/1ns

module frame_loop_tb import frame_loop_pkg::*; ();
	logic clk, reset;
	logic [num_scripts-1:0] script_en;
	logic mem_req, mem_wenable, mem_ack;
	logic [mem_addr_w-1:0] mem_addr;
	logic [mem_data_w-1:0] mem_wdata, mem_rdata;
	logic [7:0] s_axis_tdata, m_axis_tdata;
	logic s_axis_tuser, s_axis_tlast, s_axis_tvalid;
	logic m_axis_tuser, m_axis_tlast, m_axis_tvalid, m_axis_tready;

	logic [31:0] stim_lfsr, ready_lfsr;
	logic ready_random, ready_a, ready_b;
	logic [mem_data_w-1:0] cmp_word [script_len];
	logic [mem_data_w-1:0] edit_word [script_len];
	logic [7:0] frame_buf [64];
	logic [7:0] exp_data [$];
	logic exp_user [$];
	logic exp_last [$];
	int errors, bytes_sent, bytes_seen, cycles;

	frame_loop_top frame_loop_top_inst (.*);

	always #5 clk = ~clk;

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			value = {value[30:0], stim_lfsr[0]};
			stim_lfsr = lfsr_step(stim_lfsr);
		end
		return value;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			errors++;
			$display("Mismatch at %0t ns: %s = %h, expected %h", $time, name, got, expected);
		end
	endtask

	// Expected match vector from the local script tables
	function automatic logic [num_scripts-1:0] match_vec(input int len);
		logic [num_scripts-1:0] match;
		logic [7:0] mask, data;
		match = script_en;
		for (int i = 0; i < len && i < script_len; i++) begin
			for (int s = 0; s < num_scripts; s++) begin
				mask = cmp_word[i][16 * s + 8 +: 8];
				data = cmp_word[i][16 * s +: 8];
				if ((frame_buf[i] & mask) != (data & mask)) begin
					match[s] = 1'b0;
				end
			end
		end
		return match;
	endfunction

	function automatic logic [7:0] edited_byte(input logic [7:0] value, input int offset,
			input logic [num_scripts-1:0] match);
		logic [7:0] mask, data;
		int s;
		if (match == '0 || offset >= script_len) begin
			return value;
		end
		s = 0;
		while (!match[s]) begin
			s++;
		end
		mask = edit_word[offset][16 * s + 8 +: 8];
		data = edit_word[offset][16 * s +: 8];
		return (value & ~mask) | (data & mask);
	endfunction

	task automatic host_access(input logic [mem_addr_w-1:0] addr, input logic write,
			input logic [mem_data_w-1:0] wdata, output logic [mem_data_w-1:0] rdata);
		mem_req = 1'b1;
		mem_addr = addr;
		mem_wenable = write;
		mem_wdata = wdata;
		@(posedge clk);
		#1;
		// No frame traffic here, so the host is granted at once
		check_value("mem_ack", mem_ack, 1'b1);
		rdata = mem_rdata;
		mem_req = 1'b0;
		mem_wenable = 1'b0;
		@(posedge clk);
		#1;
		check_value("mem_ack", mem_ack, 1'b0);
	endtask

	task automatic send_frame(input int len, input int err_pos, input logic gaps);
		logic [num_scripts-1:0] match;
		match = match_vec(len);
		if (err_pos < 0) begin
			for (int i = 0; i < len; i++) begin
				exp_data.push_back(edited_byte(frame_buf[i], i, match));
				exp_user.push_back(|match);
				exp_last.push_back(i == len - 1);
			end
		end
		for (int i = 0; i < len; i++) begin
			if (gaps) begin
				repeat (rand_bits(2)) begin
					s_axis_tvalid = 1'b0;
					@(posedge clk);
					#1;
				end
			end
			s_axis_tvalid = 1'b1;
			s_axis_tdata = frame_buf[i];
			s_axis_tuser = (i == err_pos);
			s_axis_tlast = (i == len - 1);
			@(posedge clk);
			#1;
		end
		// Last byte samples script_en one cycle late
		s_axis_tvalid = 1'b0;
		s_axis_tuser = 1'b0;
		s_axis_tlast = 1'b0;
		@(posedge clk);
		#1;
		bytes_sent += len;
	endtask

	task automatic wait_drained();
		while (exp_data.size() != 0) begin
			@(posedge clk);
		end
		repeat (10) @(posedge clk);
		#1;
	endtask

	always @(posedge clk) begin
		#1;
		if (ready_random) begin
			ready_a = ready_lfsr[0];
			ready_lfsr = lfsr_step(ready_lfsr);
			ready_b = ready_lfsr[0];
			ready_lfsr = lfsr_step(ready_lfsr);
			m_axis_tready = ready_a | ready_b;
		end else begin
			m_axis_tready = 1'b1;
		end
	end

	always @(posedge clk) begin
		if (!reset && m_axis_tvalid && m_axis_tready) begin
			bytes_seen++;
			if (exp_data.size() == 0) begin
				errors++;
				$display("Unexpected output byte %h at %0t ns", m_axis_tdata, $time);
			end else begin
				check_value("m_axis_tdata", m_axis_tdata, exp_data.pop_front());
				check_value("m_axis_tuser", m_axis_tuser, exp_user.pop_front());
				check_value("m_axis_tlast", m_axis_tlast, exp_last.pop_front());
			end
		end
	end

	initial begin
		cycles = 0;
		#1;
		while (cycles < 40 * bytes_sent + 2000) begin
			@(posedge clk);
			cycles++;
		end
		errors++;
		$display("Timeout after %0d cycles, %0d output bytes still expected",
			cycles, exp_data.size());
		$display("Errors: %0d, bytes sent: %0d, bytes received: %0d",
			errors, bytes_sent, bytes_seen);
		$display("TEST FAIL");
		$finish;
	end

	initial begin : main_flow
		logic [mem_data_w-1:0] rd;
		int len, err_pos;
		clk = 1'b0;
		reset = 1'b1;
		stim_lfsr = 32'hc557fee0;
		ready_lfsr = 32'hc557fee0;
		ready_random = 1'b0;
		errors = 0;
		bytes_sent = 0;
		bytes_seen = 0;
		script_en = '0;
		mem_req = 1'b0;
		mem_addr = '0;
		mem_wenable = 1'b0;
		mem_wdata = '0;
		s_axis_tdata = '0;
		s_axis_tuser = 1'b0;
		s_axis_tlast = 1'b0;
		s_axis_tvalid = 1'b0;
		m_axis_tready = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;

		for (int a = 0; a < 2 ** mem_addr_w; a++) begin
			host_access(mem_addr_w'(a), 1'b1, (a + 1) * 32'h9e3779b9, rd);
		end
		for (int a = 0; a < 2 ** mem_addr_w; a++) begin
			host_access(mem_addr_w'(a), 1'b0, '0, rd);
			check_value("mem_rdata", rd, (a + 1) * 32'h9e3779b9);
		end

		// Script 0 wants 5a 01, script 1 wants 5a then 3x at offset 2
		for (int i = 0; i < script_len; i++) begin
			cmp_word[i] = '0;
			edit_word[i] = rand_bits(32);
		end
		cmp_word[0] = 32'hff5aff5a;
		cmp_word[1] = 32'h0000ff01;
		cmp_word[2] = 32'hf0300000;
		for (int i = 0; i < script_len; i++) begin
			host_access(mem_addr_w'(i), 1'b1, cmp_word[i], rd);
			host_access(mem_addr_w'(script_len + i), 1'b1, edit_word[i], rd);
		end

		script_en = 2'b11;
		for (int i = 3; i < 64; i++) begin
			frame_buf[i] = 8'(i * 37 + 11);
		end
		frame_buf[0] = 8'h5a;
		frame_buf[1] = 8'h01;
		frame_buf[2] = 8'h47;
		send_frame(24, -1, 1'b0);
		wait_drained();

		frame_buf[2] = 8'h3c;
		send_frame(20, -1, 1'b0);
		wait_drained();
		script_en = 2'b10;
		send_frame(20, -1, 1'b0);
		wait_drained();
		script_en = 2'b00;
		send_frame(20, -1, 1'b0);
		wait_drained();
		script_en = 2'b11;
		send_frame(3, -1, 1'b0);
		wait_drained();

		// Error frames between good ones, back to back
		frame_buf[2] = 8'h47;
		send_frame(24, -1, 1'b0);
		send_frame(14, 5, 1'b0);
		send_frame(10, 9, 1'b0);
		send_frame(12, -1, 1'b0);
		wait_drained();

		ready_random = 1'b1;
		for (int f = 0; f < 150; f++) begin
			len = 4 + rand_bits(6) % 37;
			for (int i = 0; i < len; i++) begin
				frame_buf[i] = 8'(rand_bits(8));
			end
			if (rand_bits(1)) begin
				frame_buf[0] = 8'h5a;
			end
			if (rand_bits(1)) begin
				frame_buf[1] = 8'h01;
			end
			if (rand_bits(1)) begin
				frame_buf[2] = 8'h30 | 8'(rand_bits(4));
			end
			script_en = num_scripts'(rand_bits(num_scripts));
			if (rand_bits(3) == 0) begin
				err_pos = rand_bits(6) % len;
			end else begin
				err_pos = -1;
			end
			send_frame(len, err_pos, 1'b1);
			repeat (rand_bits(3)) begin
				@(posedge clk);
				#1;
			end
		end
		wait_drained();

		$display("Errors: %0d, bytes sent: %0d, bytes received: %0d",
			errors, bytes_sent, bytes_seen);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end
endmodule

/* frame_loop_top.f */
source/frame_loop_pkg.sv
source/script_bus_if.sv
source/script_store.sv
source/sync_fifo.sv
source/frame_match.sv
source/frame_edit_tx.sv
source/frame_loop_top.sv
bench/frame_loop_tb.sv

/* source/frame_edit_tx.sv */
`timescale 1ns/1ns

module frame_edit_tx import frame_loop_pkg::*; (
	input logic clk,
	input logic reset,

	input frame_ctl_t ctl_rec,
	input logic ctl_empty,
	output logic ctl_pop,
	input byte_beat_t data_beat,
	input logic data_empty,
	output logic data_pop,

	script_bus_if.requester bus,

	output logic [7:0] m_axis_tdata,
	output logic m_axis_tuser,
	output logic m_axis_tlast,
	output logic m_axis_tvalid,
	input logic m_axis_tready
);
	typedef enum logic [1:0] {idle, discard, fetch, send} state_t;

	state_t state;
	logic [num_scripts-1:0] match_r;
	logic [offset_w-1:0] offset;
	logic out_free, need_edit, load;
	logic [7:0] edit_mask, edit_data, out_byte;

	// Once free, the output stays free until this block loads it
	assign out_free = ~m_axis_tvalid | m_axis_tready;
	assign need_edit = (|match_r) && (offset < script_len);

	assign ctl_pop = (state == idle) && !ctl_empty;
	assign bus.req = (state == fetch) && !data_empty && out_free && need_edit;
	assign bus.addr = {edit_region, offset[index_w-1:0]};

	assign load = ((state == fetch) && !data_empty && out_free && !need_edit)
		|| ((state == send) && bus.rvalid);
	assign data_pop = load || ((state == discard) && !data_empty);

	// Lowest matching script wins
	always_comb begin
		edit_mask = 8'h00;
		edit_data = 8'h00;
		for (int s = num_scripts - 1; s >= 0; s--) begin
			if (match_r[s]) begin
				edit_mask = bus.rdata[half_w*s+8 +: 8];
				edit_data = bus.rdata[half_w*s +: 8];
			end
		end
	end

	assign out_byte = need_edit
		? ((data_beat.data & ~edit_mask) | (edit_data & edit_mask))
		: data_beat.data;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			match_r <= '0;
			offset <= '0;
			m_axis_tvalid <= 1'b0;
		end else begin
			if (m_axis_tready) begin
				m_axis_tvalid <= 1'b0;
			end
			if (load) begin
				m_axis_tvalid <= 1'b1;
			end

			if (state == idle && !ctl_empty) begin
				match_r <= ctl_rec.match;
				offset <= '0;
				state <= ctl_rec.drop ? discard : fetch;
			end
			if (state == discard && !data_empty && data_beat.last) begin
				state <= idle;
			end
			if (state == fetch && bus.gnt) begin
				state <= send;
			end

			if (load) begin
				if (offset < script_len) begin
					offset <= offset + 1'b1;
				end
				state <= data_beat.last ? idle : fetch;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			m_axis_tdata <= out_byte;
			m_axis_tuser <= |match_r;
			m_axis_tlast <= data_beat.last;
		end
	end
endmodule

/* source/frame_loop_pkg.sv */
package frame_loop_pkg;
	localparam int num_scripts = 2;
	localparam int script_len = 16;
	localparam int mem_addr_w = 5;
	localparam int mem_data_w = 32;
	localparam int data_fifo_depth = 64;
	localparam int ctl_fifo_depth = 4;

	// Region bit sits above the frame offset
	localparam int index_w = mem_addr_w - 1;
	localparam int offset_w = index_w + 1;
	localparam logic cmp_region = 1'b0;
	localparam logic edit_region = 1'b1;

	// One half word per script, mask byte above data byte
	localparam int half_w = mem_data_w / num_scripts;

	typedef struct packed {
		logic [7:0] data;
		logic last;
	} byte_beat_t;

	typedef struct packed {
		logic [num_scripts-1:0] match;
		logic drop;
	} frame_ctl_t;
endpackage

/* source/frame_loop_top.sv */
`timescale 1ns/1ns

module frame_loop_top import frame_loop_pkg::*; (
	input logic clk,
	input logic reset,
	input logic [num_scripts-1:0] script_en,

	input logic mem_req,
	input logic [mem_addr_w-1:0] mem_addr,
	input logic mem_wenable,
	input logic [mem_data_w-1:0] mem_wdata,
	output logic [mem_data_w-1:0] mem_rdata,
	output logic mem_ack,

	input logic [7:0] s_axis_tdata,
	input logic s_axis_tuser,
	input logic s_axis_tlast,
	input logic s_axis_tvalid,

	output logic [7:0] m_axis_tdata,
	output logic m_axis_tuser,
	output logic m_axis_tlast,
	output logic m_axis_tvalid,
	input logic m_axis_tready
);
	script_bus_if match_bus ();
	script_bus_if edit_bus ();

	logic data_push, data_full, data_pop, data_empty;
	byte_beat_t data_in, data_head;
	logic ctl_push, ctl_full, ctl_pop, ctl_empty;
	frame_ctl_t ctl_in, ctl_head;

	script_store script_store_inst (
		.clk(clk),
		.reset(reset),
		.match_port(match_bus.store),
		.edit_port(edit_bus.store),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_wenable(mem_wenable),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata),
		.mem_ack(mem_ack)
	);

	frame_match frame_match_inst (
		.clk(clk),
		.reset(reset),
		.script_en(script_en),
		.s_axis_tdata(s_axis_tdata),
		.s_axis_tuser(s_axis_tuser),
		.s_axis_tlast(s_axis_tlast),
		.s_axis_tvalid(s_axis_tvalid),
		.bus(match_bus.requester),
		.data_push(data_push),
		.data_beat(data_in),
		.data_full(data_full),
		.ctl_push(ctl_push),
		.ctl_rec(ctl_in),
		.ctl_full(ctl_full)
	);

	sync_fifo #(.entry_t(byte_beat_t), .depth(data_fifo_depth)) data_fifo_inst (
		.clk(clk),
		.reset(reset),
		.push(data_push),
		.push_data(data_in),
		.pop(data_pop),
		.pop_data(data_head),
		.full(data_full),
		.empty(data_empty)
	);

	sync_fifo #(.entry_t(frame_ctl_t), .depth(ctl_fifo_depth)) ctl_fifo_inst (
		.clk(clk),
		.reset(reset),
		.push(ctl_push),
		.push_data(ctl_in),
		.pop(ctl_pop),
		.pop_data(ctl_head),
		.full(ctl_full),
		.empty(ctl_empty)
	);

	frame_edit_tx frame_edit_tx_inst (
		.clk(clk),
		.reset(reset),
		.ctl_rec(ctl_head),
		.ctl_empty(ctl_empty),
		.ctl_pop(ctl_pop),
		.data_beat(data_head),
		.data_empty(data_empty),
		.data_pop(data_pop),
		.bus(edit_bus.requester),
		.m_axis_tdata(m_axis_tdata),
		.m_axis_tuser(m_axis_tuser),
		.m_axis_tlast(m_axis_tlast),
		.m_axis_tvalid(m_axis_tvalid),
		.m_axis_tready(m_axis_tready)
	);
endmodule

/* source/frame_match.sv */
`timescale 1ns/1ns

module frame_match import frame_loop_pkg::*; (
	input logic clk,
	input logic reset,
	input logic [num_scripts-1:0] script_en,

	input logic [7:0] s_axis_tdata,
	input logic s_axis_tuser,
	input logic s_axis_tlast,
	input logic s_axis_tvalid,

	script_bus_if.requester bus,

	output logic data_push,
	output byte_beat_t data_beat,
	input logic data_full,
	output logic ctl_push,
	output frame_ctl_t ctl_rec,
	input logic ctl_full
);
	logic [offset_w-1:0] offset;
	logic d_valid, d_first, d_user, d_last;
	logic [7:0] d_data;
	logic [num_scripts-1:0] hit, match_r, match_now;
	logic skip_r, err_r, ovf_r;
	logic skip_now, err_now, ovf_now, write_byte;
	logic pend_last;
	logic [7:0] pend_data;

	// Compare word read while the byte arrives
	assign bus.req = s_axis_tvalid && (offset < script_len);
	assign bus.addr = {cmp_region, offset[index_w-1:0]};

	always_ff @(posedge clk) begin
		if (reset) begin
			offset <= '0;
			d_valid <= 1'b0;
		end else begin
			d_valid <= s_axis_tvalid;
			if (s_axis_tvalid && s_axis_tlast) begin
				offset <= '0;
			end else if (s_axis_tvalid && offset < script_len) begin
				offset <= offset + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		d_data <= s_axis_tdata;
		d_user <= s_axis_tuser;
		d_last <= s_axis_tlast;
		d_first <= (offset == '0);
	end

	always_comb begin
		for (int s = 0; s < num_scripts; s++) begin
			hit[s] = ((d_data ^ bus.rdata[half_w*s +: 8]) & bus.rdata[half_w*s+8 +: 8]) == 8'h00;
		end
	end

	// Frame state, restarted on the first byte
	assign match_now = (d_first ? {num_scripts{1'b1}} : match_r)
		& (bus.rvalid ? hit : {num_scripts{1'b1}});
	assign skip_now = d_first ? (ctl_full | pend_last) : skip_r;
	assign err_now = (~d_first & err_r) | d_user;
	assign ovf_now = (~d_first & ovf_r) | data_full;
	assign write_byte = d_valid & ~skip_now & (~ovf_now | d_last);

	// A last byte that met a full buffer is pushed once room appears
	assign data_push = pend_last | write_byte;
	assign data_beat.data = pend_last ? pend_data : d_data;
	assign data_beat.last = pend_last | d_last;

	assign ctl_push = d_valid & d_last & ~skip_now;
	assign ctl_rec.match = match_now & script_en & {num_scripts{~err_now}};
	assign ctl_rec.drop = err_now | ovf_now;

	always_ff @(posedge clk) begin
		if (reset) begin
			match_r <= '0;
			skip_r <= 1'b0;
			err_r <= 1'b0;
			ovf_r <= 1'b0;
			pend_last <= 1'b0;
		end else begin
			if (d_valid) begin
				match_r <= match_now;
				skip_r <= skip_now;
				err_r <= err_now;
				ovf_r <= ovf_now;
			end
			if (write_byte && d_last && data_full) begin
				pend_last <= 1'b1;
			end else if (pend_last && !data_full) begin
				pend_last <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (write_byte && d_last && data_full) begin
			pend_data <= d_data;
		end
	end
endmodule

/* source/script_bus_if.sv */
`timescale 1ns/1ns

interface script_bus_if import frame_loop_pkg::*; ();
	logic req;
	logic [mem_addr_w-1:0] addr;
	logic gnt;
	logic [mem_data_w-1:0] rdata;
	logic rvalid;

	modport requester (
		output req,
		output addr,
		input gnt,
		input rdata,
		input rvalid
	);

	modport store (
		input req,
		input addr,
		output gnt,
		output rdata,
		output rvalid
	);
endinterface

/* source/script_store.sv */
`timescale 1ns/1ns

module script_store import frame_loop_pkg::*; (
	input logic clk,
	input logic reset,

	script_bus_if.store match_port,
	script_bus_if.store edit_port,

	input logic mem_req,
	input logic [mem_addr_w-1:0] mem_addr,
	input logic mem_wenable,
	input logic [mem_data_w-1:0] mem_wdata,
	output logic [mem_data_w-1:0] mem_rdata,
	output logic mem_ack
);
	logic [mem_data_w-1:0] mem [2**mem_addr_w];
	logic [mem_data_w-1:0] rd_data;
	logic [mem_addr_w-1:0] sel_addr;
	logic grant_match, grant_edit, grant_host;
	logic match_rvalid, edit_rvalid;

	// Matcher first, then editor, then host
	always_comb begin
		grant_match = match_port.req;
		grant_edit = edit_port.req & ~match_port.req;
		// Host is still holding req in its ack cycle
		grant_host = mem_req & ~mem_ack & ~match_port.req & ~edit_port.req;

		if (grant_match) begin
			sel_addr = match_port.addr;
		end else if (grant_edit) begin
			sel_addr = edit_port.addr;
		end else begin
			sel_addr = mem_addr;
		end
	end

	assign match_port.gnt = grant_match;
	assign edit_port.gnt = grant_edit;

	// Single synchronous port
	always_ff @(posedge clk) begin
		if (grant_host && mem_wenable) begin
			mem[sel_addr] <= mem_wdata;
		end
		rd_data <= mem[sel_addr];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			match_rvalid <= 1'b0;
			edit_rvalid <= 1'b0;
			mem_ack <= 1'b0;
		end else begin
			match_rvalid <= grant_match;
			edit_rvalid <= grant_edit;
			mem_ack <= grant_host;
		end
	end

	// Read data goes to whoever was granted last cycle
	assign match_port.rvalid = match_rvalid;
	assign match_port.rdata = rd_data;
	assign edit_port.rvalid = edit_rvalid;
	assign edit_port.rdata = rd_data;
	assign mem_rdata = rd_data;
endmodule

/* source/sync_fifo.sv */
`timescale 1ns/1ns

module sync_fifo #(
	parameter type entry_t = logic [7:0],
	parameter int depth = 4
) (
	input logic clk,
	input logic reset,
	input logic push,
	input entry_t push_data,
	input logic pop,
	output entry_t pop_data,
	output logic full,
	output logic empty
);
	entry_t mem [depth];
	logic [$clog2(depth)-1:0] wr_ptr, rd_ptr;
	logic [$clog2(depth):0] count;
	logic do_push, do_pop;

	assign full = (count == depth);
	assign empty = (count == 0);
	assign do_push = push & ~full;
	assign do_pop = pop & ~empty;

	// Head entry is visible without a pop
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == depth - 1) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == depth - 1) ? '0 : rd_ptr + 1'b1;
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end
endmodule
